// ==== src/sd_defs.svh ====
`ifndef SD_DEFS_SVH
`define SD_DEFS_SVH

`default_nettype none

// card clock half-periods in clk cycles, clk is 100 MHz

// 100 MHz / (2 * 125) = 400 kHz for identification
`define SD_DIV_SLOW 125

// 100 MHz / (2 * 2) = 25 MHz once the card is ready
`define SD_DIV_FAST 2

// card clocks with cs high before CMD0, the spec asks for at least 74
`define SD_POWERUP_CLKS 80

// card clocks to wait for the response start bit
`define SD_RESP_TIMEOUT 100

// attempts for CMD0 and for each CMD55/ACMD41 pair
`define SD_MAX_RETRY 10

`default_nettype wire

`endif

// ==== src/sd_pkg.sv ====
`default_nettype none

package sd_pkg;

  // index and argument as picked by the sequencer
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] arg;
  } sd_cmd_t;

  // 48-bit frame, sent msb first
  typedef struct packed {
    logic [1:0]  start;
    logic [5:0]  index;
    logic [31:0] arg;
    logic [6:0]  crc;
    logic        stop;
  } sd_frame_t;

  // long_resp set means a 40-bit response (R3/R7), else R1 only
  typedef struct packed {
    sd_frame_t frame;
    logic      long_resp;
  } sd_xfer_t;

  // R7, answer to CMD8
  typedef struct packed {
    logic [7:0]  r1;
    logic [3:0]  version;
    logic [15:0] reserved;
    logic [3:0]  voltage;
    logic [7:0]  pattern;
  } sd_r7_t;

  // R3, answer to CMD58
  typedef struct packed {
    logic [7:0]  r1;
    logic [31:0] ocr;
  } sd_r3_t;

  // same 40 bits seen as R7 or R3, a short R1 sits in the top byte
  typedef union packed {
    sd_r7_t r7;
    sd_r3_t r3;
  } sd_resp_u;

  typedef struct packed {
    sd_resp_u resp;
    logic     timeout;
  } sd_result_t;

  typedef enum logic [2:0] {
    FAIL_NONE,
    FAIL_CMD0,
    FAIL_CMD8,
    FAIL_CMD58,
    FAIL_ACMD41
  } sd_fail_t;

endpackage

`default_nettype wire

// ==== src/sd_cmd_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_framer (
  input  wire                clk,
  input  wire                rst,
  input  wire                cmd_valid,
  input  wire sd_pkg::sd_cmd_t cmd,
  input  wire                long_resp,
  output logic               xfer_start,
  output sd_pkg::sd_xfer_t   xfer
);

  // start bits, index and argument, the part covered by the crc
  logic [39:0] head;

  // crc7, generator x^7 + x^3 + 1, msb first
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] c;
    logic       fb;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      fb = data[i] ^ c[6];
      c = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  assign head = {2'b01, cmd.index, cmd.arg};

  // strobe follows cmd_valid by exactly one clk
  always_ff @(posedge clk) begin
    if (rst) begin
      xfer_start <= 1'b0;
    end else begin
      xfer_start <= cmd_valid;
    end
  end

  // frame payload, loaded only on a new command
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      xfer.frame.start <= 2'b01;
      xfer.frame.index <= cmd.index;
      xfer.frame.arg   <= cmd.arg;
      xfer.frame.crc   <= crc7(head);
      xfer.frame.stop  <= 1'b1;
      xfer.long_resp   <= long_resp;
    end
  end

  // go-idle frame closes with the fixed byte 0x95, crc and end bit together
  a_frame_out: assert property (@(posedge clk) disable iff (rst)
    xfer_start && xfer.frame.index == 6'd0 && xfer.frame.arg == 32'h0000_0000 |->
      {xfer.frame.crc, xfer.frame.stop} == 8'h95);

endmodule

`default_nettype wire

// ==== src/sd_spi_link.sv ====
`timescale 1ns/1ps
`include "sd_defs.svh"
`default_nettype none

module sd_spi_link (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   xfer_start,
  input  wire sd_pkg::sd_xfer_t xfer,
  input  wire                   clk_fast,
  output logic                  powered,
  output logic                  xfer_done,
  output sd_pkg::sd_result_t    result,
  output logic                  sd_cclk,
  output logic                  sd_mosi,
  output logic                  sd_cs,
  input  wire                   sd_miso
);

  localparam logic [2:0] ST_PWR  = 3'd0;
  localparam logic [2:0] ST_IDLE = 3'd1;
  localparam logic [2:0] ST_SEND = 3'd2;
  localparam logic [2:0] ST_RESP = 3'd3;
  localparam logic [2:0] ST_END  = 3'd4;

  logic [2:0]  state;
  logic [7:0]  div_cnt;
  logic [7:0]  half;
  logic        tick;
  logic        rise;
  logic        fall;
  logic [6:0]  pwr_cnt;
  logic [5:0]  bit_cnt;
  logic [6:0]  wait_cnt;
  logic [5:0]  rx_cnt;
  logic        started;
  logic        fast_q;
  logic        long_q;
  logic [47:0] tx_sr;
  logic [39:0] rx_sr;

  // power-up always slow, speed latched per transfer
  assign half = (state == ST_PWR || !fast_q) ? 8'(`SD_DIV_SLOW) : 8'(`SD_DIV_FAST);
  // clock parked low while idle
  assign tick = (state != ST_IDLE) && (div_cnt == half - 8'd1);
  assign rise = tick && !sd_cclk;
  assign fall = tick && sd_cclk;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= ST_PWR;
      sd_cs     <= 1'b1;
      sd_cclk   <= 1'b0;
      sd_mosi   <= 1'b1;
      div_cnt   <= '0;
      pwr_cnt   <= '0;
      bit_cnt   <= '0;
      wait_cnt  <= '0;
      rx_cnt    <= '0;
      started   <= 1'b0;
      fast_q    <= 1'b0;
      long_q    <= 1'b0;
      powered   <= 1'b0;
      xfer_done <= 1'b0;
    end else begin
      powered   <= 1'b0;
      xfer_done <= 1'b0;
      // card clock divider
      if (state == ST_IDLE) begin
        div_cnt <= '0;
        sd_cclk <= 1'b0;
      end else if (tick) begin
        div_cnt <= '0;
        sd_cclk <= ~sd_cclk;
      end else begin
        div_cnt <= div_cnt + 8'd1;
      end
      case (state)
        ST_PWR: begin
          if (rise) begin
            pwr_cnt <= pwr_cnt + 7'd1;
          end
          // leave on the falling edge after the last power-up clock
          if (fall && pwr_cnt == 7'(`SD_POWERUP_CLKS)) begin
            sd_cs   <= 1'b0;
            powered <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (xfer_start) begin
            // first bit goes out before the first rising edge
            tx_sr   <= xfer.frame;
            sd_mosi <= xfer.frame.start[1];
            fast_q  <= clk_fast;
            long_q  <= xfer.long_resp;
            bit_cnt <= '0;
            state   <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (rise) begin
            bit_cnt <= bit_cnt + 6'd1;
          end
          if (fall) begin
            if (bit_cnt == 6'd48) begin
              sd_mosi  <= 1'b1;
              wait_cnt <= '0;
              rx_cnt   <= '0;
              started  <= 1'b0;
              state    <= ST_RESP;
            end else begin
              sd_mosi <= tx_sr[46];
              tx_sr   <= {tx_sr[46:0], 1'b1};
            end
          end
        end
        ST_RESP: begin
          if (rise) begin
            if (started || !sd_miso) begin
              // start bit is the msb of r1
              started <= 1'b1;
              rx_sr   <= {rx_sr[38:0], sd_miso};
              rx_cnt  <= rx_cnt + 6'd1;
              if (rx_cnt == (long_q ? 6'd39 : 6'd7)) begin
                if (long_q) begin
                  result <= {rx_sr[38:0], sd_miso, 1'b0};
                end else begin
                  result <= {rx_sr[6:0], sd_miso, 32'hFFFF_FFFF, 1'b0};
                end
                state <= ST_END;
              end
            end else begin
              wait_cnt <= wait_cnt + 7'd1;
              if (wait_cnt == 7'(`SD_RESP_TIMEOUT - 1)) begin
                // idle line reads as all ones
                result <= {40'hFF_FFFF_FFFF, 1'b1};
                state  <= ST_END;
              end
            end
          end
        end
        ST_END: begin
          // finish with the clock low again
          if (fall) begin
            xfer_done <= 1'b1;
            state     <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // sequencer must wait for xfer_done before the next command
  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    xfer_start |-> state == ST_IDLE);

endmodule

`default_nettype wire

// ==== src/sd_init_seq.sv ====
`timescale 1ns/1ps
`include "sd_defs.svh"
`default_nettype none

module sd_init_seq (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     powered,
  output logic                    cmd_valid,
  output sd_pkg::sd_cmd_t         cmd,
  output logic                    long_resp,
  input  wire                     xfer_done,
  input  wire sd_pkg::sd_result_t result,
  output logic                    clk_fast,
  output logic                    init_done,
  output logic                    init_error,
  output sd_pkg::sd_fail_t        fail_stage,
  output logic                    card_hc
);

  localparam logic [3:0] S_WAIT_PWR = 4'd0;
  localparam logic [3:0] S_CMD0     = 4'd1;
  localparam logic [3:0] S_CMD8     = 4'd2;
  localparam logic [3:0] S_CMD58A   = 4'd3;
  localparam logic [3:0] S_CMD55    = 4'd4;
  localparam logic [3:0] S_ACMD41   = 4'd5;
  localparam logic [3:0] S_CMD58B   = 4'd6;
  localparam logic [3:0] S_DONE     = 4'd7;
  localparam logic [3:0] S_ERROR    = 4'd8;

  logic [3:0]       state;
  logic             pending;
  logic [3:0]       retry_cnt;
  logic [7:0]       r1;
  sd_pkg::sd_cmd_t  next_cmd;
  logic             next_long;

  assign r1 = result.resp.r7.r1;

  // command belonging to each step
  always_comb begin
    next_cmd  = '0;
    next_long = 1'b0;
    case (state)
      // go idle, crc 0x95 required here
      S_CMD0: next_cmd = '{index: 6'd0, arg: 32'h0000_0000};
      // 2.7-3.6 V and check pattern 0xAA
      S_CMD8: begin
        next_cmd  = '{index: 6'd8, arg: 32'h0000_01AA};
        next_long = 1'b1;
      end
      // read ocr
      S_CMD58A, S_CMD58B: begin
        next_cmd  = '{index: 6'd58, arg: 32'h0000_0000};
        next_long = 1'b1;
      end
      S_CMD55: next_cmd = '{index: 6'd55, arg: 32'h0000_0000};
      // hcs set
      S_ACMD41: next_cmd = '{index: 6'd41, arg: 32'h4000_0000};
      default: next_cmd = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_WAIT_PWR;
      pending    <= 1'b0;
      retry_cnt  <= '0;
      cmd_valid  <= 1'b0;
      clk_fast   <= 1'b0;
      init_done  <= 1'b0;
      init_error <= 1'b0;
      fail_stage <= sd_pkg::FAIL_NONE;
      card_hc    <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (state == S_WAIT_PWR) begin
        if (powered) begin
          state <= S_CMD0;
        end
      end else if (state != S_DONE && state != S_ERROR && !pending) begin
        // one command in flight at a time
        cmd_valid <= 1'b1;
        cmd       <= next_cmd;
        long_resp <= next_long;
        pending   <= 1'b1;
      end else if (pending && xfer_done) begin
        pending <= 1'b0;
        case (state)
          S_CMD0: begin
            if (!result.timeout && r1 == 8'h01) begin
              retry_cnt <= '0;
              state     <= S_CMD8;
            end else if (retry_cnt == 4'(`SD_MAX_RETRY - 1)) begin
              init_error <= 1'b1;
              fail_stage <= sd_pkg::FAIL_CMD0;
              state      <= S_ERROR;
            end else begin
              retry_cnt <= retry_cnt + 4'd1;
            end
          end
          S_CMD8: begin
            // 0x05 is illegal command, a v1 card
            if (!result.timeout && (r1 == 8'h05 || (r1 == 8'h01 &&
                result.resp.r7.voltage == 4'h1 && result.resp.r7.pattern == 8'hAA))) begin
              state <= S_CMD58A;
            end else begin
              init_error <= 1'b1;
              fail_stage <= sd_pkg::FAIL_CMD8;
              state      <= S_ERROR;
            end
          end
          S_CMD58A, S_CMD58B: begin
            if (result.timeout) begin
              init_error <= 1'b1;
              fail_stage <= sd_pkg::FAIL_CMD58;
              state      <= S_ERROR;
            end else if (state == S_CMD58A) begin
              retry_cnt <= '0;
              state     <= S_CMD55;
            end else begin
              // ccs, valid now that the card is powered up
              card_hc   <= result.resp.r3.ocr[30];
              init_done <= 1'b1;
              state     <= S_DONE;
            end
          end
          S_CMD55: begin
            // idle or ready both fine here
            if (!result.timeout && r1[7:1] == 7'd0) begin
              state <= S_ACMD41;
            end else begin
              init_error <= 1'b1;
              fail_stage <= sd_pkg::FAIL_ACMD41;
              state      <= S_ERROR;
            end
          end
          S_ACMD41: begin
            if (!result.timeout && r1 == 8'h00) begin
              // card ready, rest runs fast
              clk_fast <= 1'b1;
              state    <= S_CMD58B;
            end else if (!result.timeout && r1 == 8'h01 &&
                         retry_cnt != 4'(`SD_MAX_RETRY - 1)) begin
              retry_cnt <= retry_cnt + 4'd1;
              state     <= S_CMD55;
            end else begin
              init_error <= 1'b1;
              fail_stage <= sd_pkg::FAIL_ACMD41;
              state      <= S_ERROR;
            end
          end
          default: begin
            state <= S_ERROR;
          end
        endcase
      end
    end
  end

  a_one_outcome: assert property (@(posedge clk) disable iff (rst)
    !(init_done && init_error));

endmodule

`default_nettype wire

// ==== src/sd_spi_init.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_spi_init (
  input  wire              clk,
  input  wire              rst,
  output logic             sd_cclk,
  output logic             sd_mosi,
  output logic             sd_cs,
  input  wire              sd_miso,
  output logic             init_done,
  output logic             init_error,
  output sd_pkg::sd_fail_t fail_stage,
  output logic             card_hc
);

  // sequencer to framer
  logic               cmd_valid;
  sd_pkg::sd_cmd_t    cmd;
  logic               long_resp;
  // framer to link
  logic               xfer_start;
  sd_pkg::sd_xfer_t   xfer;
  // link back to sequencer
  logic               powered;
  logic               xfer_done;
  sd_pkg::sd_result_t result;
  logic               clk_fast;

  sd_init_seq sd_init_seq_i (
    .clk        (clk),
    .rst        (rst),
    .powered    (powered),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .long_resp  (long_resp),
    .xfer_done  (xfer_done),
    .result     (result),
    .clk_fast   (clk_fast),
    .init_done  (init_done),
    .init_error (init_error),
    .fail_stage (fail_stage),
    .card_hc    (card_hc)
  );

  sd_cmd_framer sd_cmd_framer_i (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .long_resp  (long_resp),
    .xfer_start (xfer_start),
    .xfer       (xfer)
  );

  sd_spi_link sd_spi_link_i (
    .clk        (clk),
    .rst        (rst),
    .xfer_start (xfer_start),
    .xfer       (xfer),
    .clk_fast   (clk_fast),
    .powered    (powered),
    .xfer_done  (xfer_done),
    .result     (result),
    .sd_cclk    (sd_cclk),
    .sd_mosi    (sd_mosi),
    .sd_cs      (sd_cs),
    .sd_miso    (sd_miso)
  );

endmodule

`default_nettype wire

// ==== dv/sd_card_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
  input  wire               sd_cclk,
  input  wire               sd_cs,
  input  wire               sd_mosi,
  output logic              sd_miso,
  input  wire  [2:0]        mode,
  input  wire  [29:0]       ocr_low,
  output sd_pkg::sd_frame_t frame,
  output int                frame_cnt
);

  // card personalities
  localparam logic [2:0] MODE_V2_HC     = 3'd0;
  localparam logic [2:0] MODE_V1        = 3'd1;
  localparam logic [2:0] MODE_BAD_ECHO  = 3'd2;
  localparam logic [2:0] MODE_NEVER_RDY = 3'd3;
  localparam logic [2:0] MODE_SILENT    = 3'd4;

  // Ncr, idle clocks between end bit and response
  localparam int NCR = 8;

  logic        in_frame;
  logic [5:0]  rx_bits;
  logic [46:0] rx_sr;
  logic [39:0] tx_sr;
  int          tx_left;
  int          gap;
  logic        ready;
  int          acmd41_cnt;

  initial begin
    sd_miso    = 1'b1;
    frame      = '0;
    frame_cnt  = 0;
    in_frame   = 1'b0;
    rx_bits    = '0;
    rx_sr      = '0;
    tx_sr      = '1;
    tx_left    = 0;
    gap        = 0;
    ready      = 1'b0;
    acmd41_cnt = 0;
  end

  always @(posedge sd_cclk or negedge sd_cclk) begin : card
    logic [47:0]       nxt;
    sd_pkg::sd_frame_t got;
    logic [39:0]       resp;
    int                resp_len;
    if (sd_cs) begin
      // deselected, power-up clocks land here too
      in_frame   <= 1'b0;
      rx_bits    <= '0;
      tx_left    <= 0;
      gap        <= 0;
      ready      <= 1'b0;
      acmd41_cnt <= 0;
      sd_miso    <= 1'b1;
    end else if (sd_cclk) begin
      // mosi sampled on the rising edge, a 0 opens a frame
      if (in_frame || !sd_mosi) begin
        nxt = {rx_sr, sd_mosi};
        got = nxt;
        rx_sr <= nxt[46:0];
        if (rx_bits == 6'd47) begin
          in_frame  <= 1'b0;
          rx_bits   <= '0;
          frame     <= got;
          frame_cnt <= frame_cnt + 1;
          // unknown index answers illegal command
          resp_len = 8;
          resp = {8'h04, 32'hFFFF_FFFF};
          case (got.index)
            6'd0: resp = {8'h01, 32'hFFFF_FFFF};
            6'd8: begin
              if (mode == MODE_V1) begin
                resp = {8'h05, 32'hFFFF_FFFF};
              end else begin
                // echo voltage, pattern spoiled on request
                resp = {8'h01, 4'h0, 16'h0000, got.arg[11:8],
                        (mode == MODE_BAD_ECHO) ? 8'h55 : got.arg[7:0]};
                resp_len = 40;
              end
            end
            6'd58: begin
              // busy bit 31 and ccs bit 30 only once ready
              resp = {ready ? 8'h00 : 8'h01, ready, ready && mode == MODE_V2_HC, ocr_low};
              resp_len = 40;
            end
            6'd55: resp = {ready ? 8'h00 : 8'h01, 32'hFFFF_FFFF};
            6'd41: begin
              // ready from the second ACMD41 on
              if (mode != MODE_NEVER_RDY && acmd41_cnt >= 1) begin
                ready <= 1'b1;
                resp = {8'h00, 32'hFFFF_FFFF};
              end else begin
                resp = {8'h01, 32'hFFFF_FFFF};
              end
              acmd41_cnt <= acmd41_cnt + 1;
            end
            default: resp_len = 8;
          endcase
          if (mode != MODE_SILENT) begin
            tx_sr   <= resp;
            tx_left <= resp_len;
            gap     <= NCR;
          end
        end else begin
          in_frame <= 1'b1;
          rx_bits  <= rx_bits + 6'd1;
        end
      end
    end else begin
      // miso moves after the falling edge
      if (gap > 0) begin
        gap     <= gap - 1;
        sd_miso <= 1'b1;
      end else if (tx_left > 0) begin
        sd_miso <= tx_sr[39];
        tx_sr   <= {tx_sr[38:0], 1'b1};
        tx_left <= tx_left - 1;
      end else begin
        sd_miso <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_sd_spi_init.sv ====
`timescale 1ns/1ps
`include "sd_defs.svh"
`default_nettype none

module tb_sd_spi_init;

  // card model personalities
  localparam logic [2:0] MODE_V2_HC     = 3'd0;
  localparam logic [2:0] MODE_V1        = 3'd1;
  localparam logic [2:0] MODE_BAD_ECHO  = 3'd2;
  localparam logic [2:0] MODE_NEVER_RDY = 3'd3;
  localparam logic [2:0] MODE_SILENT    = 3'd4;

  // slow card clock is 250 clks, a command takes at most ~150 card clocks,
  // never-ready card needs 23 commands, six runs come to ~1.3M clks
  localparam int CYCLE_LIMIT = 3_000_000;

  logic              clk = 1'b0;
  logic              rst;
  logic              sd_cclk;
  logic              sd_mosi;
  logic              sd_cs;
  logic              sd_miso;
  logic              init_done;
  logic              init_error;
  sd_pkg::sd_fail_t  fail_stage;
  logic              card_hc;
  logic [2:0]        mode;
  logic [29:0]       ocr_low;
  sd_pkg::sd_frame_t frame;
  int                frame_cnt;

  string test_name;
  int    error_cnt;
  int    frame_errs = 0;
  int    cycle_cnt = 0;

  // monitor state, cleared while rst is high
  logic       cclk_prev = 1'b0;
  int         run_len = 0;
  int         half_meas = 0;
  int         pwr_rises;
  int         rises_at_first;
  int         frames_seen;
  int         seen_cnt;
  logic       cs_dropped;
  logic       cs_back_high;
  int         n_cmd0;
  int         n_acmd41;
  int         last58_half;
  logic [7:0] cmd0_byte;
  logic [7:0] cmd8_byte;

  sd_spi_init sd_spi_init_i (
    .clk        (clk),
    .rst        (rst),
    .sd_cclk    (sd_cclk),
    .sd_mosi    (sd_mosi),
    .sd_cs      (sd_cs),
    .sd_miso    (sd_miso),
    .init_done  (init_done),
    .init_error (init_error),
    .fail_stage (fail_stage),
    .card_hc    (card_hc)
  );

  sd_card_model sd_card_model_i (
    .sd_cclk   (sd_cclk),
    .sd_cs     (sd_cs),
    .sd_mosi   (sd_mosi),
    .sd_miso   (sd_miso),
    .mode      (mode),
    .ocr_low   (ocr_low),
    .frame     (frame),
    .frame_cnt (frame_cnt)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout: no init result after %0d clock cycles in %s", CYCLE_LIMIT, test_name);
      $display("TEST FAILED");
      $finish;
    end
  end

  // crc7 over start, index and argument, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] r;
    logic       in_bit;
    r = 7'd0;
    for (int k = 0; k < 40; k++) begin
      in_bit = bits[39 - k] ^ r[6];
      r = {r[5:3], r[2] ^ in_bit, r[1:0], in_bit};
    end
    return r;
  endfunction

  task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      error_cnt++;
      $display("** Error %s: %s expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic compare_stage(input string what, input sd_pkg::sd_fail_t exp,
                               input sd_pkg::sd_fail_t act);
    if (act !== exp) begin
      error_cnt++;
      $display("** Error %s: %s expected %s, actual %s", test_name, what, exp.name(),
               act.name());
    end
  endtask

  task automatic match_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      error_cnt++;
      $display("** Error %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic verify_count(input string what, input int exp, input int act);
    if (act != exp) begin
      error_cnt++;
      $display("** Error %s: %s expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  // every frame the card saw, crc from our own generator
  task automatic inspect_frame;
    logic [6:0] want;
    want = crc7_of({frame.start, frame.index, frame.arg});
    if (frames_seen == 0) begin
      rises_at_first = pwr_rises;
    end
    frames_seen++;
    if (frame.start !== 2'b01 || frame.crc !== want || frame.stop !== 1'b1) begin
      frame_errs++;
      $display("** Error %s: CMD%0d frame expected start 01 crc %h end 1, actual %b %h %b",
               test_name, frame.index, want, frame.start, frame.crc, frame.stop);
    end
    case (frame.index)
      6'd0: begin
        n_cmd0++;
        cmd0_byte = {frame.crc, frame.stop};
      end
      6'd8: cmd8_byte = {frame.crc, frame.stop};
      6'd41: n_acmd41++;
      // half-period seen while this CMD58 went out
      6'd58: last58_half = half_meas;
      default: begin
      end
    endcase
  endtask

  always @(negedge clk) begin : monitor
    logic rise;
    rise = sd_cclk && !cclk_prev;
    if (sd_cclk != cclk_prev) begin
      half_meas = run_len;
      run_len   = 1;
    end else begin
      run_len = run_len + 1;
    end
    cclk_prev = sd_cclk;
    if (rst) begin
      pwr_rises      = 0;
      rises_at_first = 0;
      frames_seen    = 0;
      cs_dropped     = 1'b0;
      cs_back_high   = 1'b0;
      n_cmd0         = 0;
      n_acmd41       = 0;
      last58_half    = 0;
      cmd0_byte      = '0;
      cmd8_byte      = '0;
      seen_cnt       = frame_cnt;
    end else begin
      if (rise && sd_cs) begin
        pwr_rises++;
      end
      if (!sd_cs) begin
        cs_dropped = 1'b1;
      end else if (cs_dropped) begin
        cs_back_high = 1'b1;
      end
      if (frame_cnt != seen_cnt) begin
        seen_cnt = frame_cnt;
        inspect_frame();
      end
    end
  end

  // reset for 10 cycles with a new card behind it
  task automatic start_card(input string name, input logic [2:0] card_mode);
    test_name = name;
    @(posedge clk);
    rst     <= 1'b1;
    mode    <= card_mode;
    ocr_low <= 30'($urandom());
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic wait_outcome;
    @(negedge clk);
    while (!init_done && !init_error) begin
      @(negedge clk);
    end
  endtask

  task automatic power_up_test;
    start_card("power_up", MODE_V2_HC);
    @(negedge clk);
    check_level("sd_cs after reset", 1'b1, sd_cs);
    check_level("sd_cclk after reset", 1'b0, sd_cclk);
    check_level("init_done after reset", 1'b0, init_done);
    check_level("init_error after reset", 1'b0, init_error);
    check_level("card_hc after reset", 1'b0, card_hc);
    wait_outcome();
    if (rises_at_first < `SD_POWERUP_CLKS) begin
      error_cnt++;
      $display("** Error %s: power-up clocks expected at least %0d, actual %0d", test_name,
               `SD_POWERUP_CLKS, rises_at_first);
    end
    check_level("sd_cs after power-up", 1'b0, sd_cs);
    check_level("sd_cs high again", 1'b0, cs_back_high);
  endtask

  task automatic v2_card_test;
    start_card("v2_hc_card", MODE_V2_HC);
    wait_outcome();
    check_level("init_done", 1'b1, init_done);
    check_level("init_error", 1'b0, init_error);
    check_level("card_hc", 1'b1, card_hc);
    compare_stage("fail_stage", sd_pkg::FAIL_NONE, fail_stage);
    match_byte("CMD0 crc byte", 8'h95, cmd0_byte);
    match_byte("CMD8 crc byte", 8'h87, cmd8_byte);
    verify_count("final CMD58 half-period", `SD_DIV_FAST, last58_half);
  endtask

  task automatic v1_card_test;
    start_card("v1_card", MODE_V1);
    wait_outcome();
    check_level("init_done", 1'b1, init_done);
    check_level("init_error", 1'b0, init_error);
    check_level("card_hc", 1'b0, card_hc);
  endtask

  task automatic bad_echo_test;
    start_card("bad_check_pattern", MODE_BAD_ECHO);
    wait_outcome();
    check_level("init_done", 1'b0, init_done);
    check_level("init_error", 1'b1, init_error);
    compare_stage("fail_stage", sd_pkg::FAIL_CMD8, fail_stage);
  endtask

  task automatic never_ready_test;
    start_card("never_ready", MODE_NEVER_RDY);
    wait_outcome();
    check_level("init_done", 1'b0, init_done);
    check_level("init_error", 1'b1, init_error);
    compare_stage("fail_stage", sd_pkg::FAIL_ACMD41, fail_stage);
    verify_count("ACMD41 frames", `SD_MAX_RETRY, n_acmd41);
  endtask

  task automatic silent_card_test;
    start_card("silent_card", MODE_SILENT);
    wait_outcome();
    check_level("init_done", 1'b0, init_done);
    check_level("init_error", 1'b1, init_error);
    compare_stage("fail_stage", sd_pkg::FAIL_CMD0, fail_stage);
    verify_count("CMD0 frames", `SD_MAX_RETRY, n_cmd0);
  endtask

  initial begin
    rst       = 1'b1;
    mode      = MODE_V2_HC;
    ocr_low   = '0;
    error_cnt = 0;
    test_name = "startup";
    void'($urandom(80068));
    power_up_test();
    v2_card_test();
    v1_card_test();
    bad_echo_test();
    never_ready_test();
    silent_card_test();
    $display("failed checks: %0d, bad frames: %0d", error_cnt, frame_errs);
    if (error_cnt == 0 && frame_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/sd_pkg.sv
src/sd_cmd_framer.sv
src/sd_spi_link.sv
src/sd_init_seq.sv
src/sd_spi_init.sv
dv/sd_card_model.sv
dv/tb_sd_spi_init.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the SD SPI init testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_sd_spi_init -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vtb_sd_spi_init)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
